//--- src/lsuPkg.sv
`default_nettype none

package lsuPkg;

	////////////////////////////////////////////////////////////
	// memory geometry
	////////////////////////////////////////////////////////////
	localparam int blockBits = 128;                     // bits per block
	localparam int blockBytes = blockBits / 8;          // 16 bytes per block
	localparam int offsetBits = $clog2(blockBytes);     // byte offset inside a block
	localparam int maxIndexBits = 16;                   // widest block index a commit carries

	typedef logic [4:0] regAddr_t;                      // register number
	typedef logic [63:0] dataWord_t;                    // register value or EA
	typedef logic [0:blockBits-1] block_t;              // big endian, byte 0 in bits [0:7]

	typedef enum logic [1:0] {
		sizeByte,
		sizeHalf,
		sizeWord
	} accessSize_e;

	////////////////////////////////////////////////////////////
	// D-form opcodes kept by this unit
	////////////////////////////////////////////////////////////
	localparam logic [5:0] opLwz = 6'd32;
	localparam logic [5:0] opLwzu = 6'd33;
	localparam logic [5:0] opLbz = 6'd34;
	localparam logic [5:0] opLbzu = 6'd35;
	localparam logic [5:0] opStw = 6'd36;
	localparam logic [5:0] opStwu = 6'd37;
	localparam logic [5:0] opStb = 6'd38;
	localparam logic [5:0] opStbu = 6'd39;
	localparam logic [5:0] opLhz = 6'd40;
	localparam logic [5:0] opLhzu = 6'd41;
	localparam logic [5:0] opLha = 6'd42;
	localparam logic [5:0] opLhau = 6'd43;
	localparam logic [5:0] opSth = 6'd44;
	localparam logic [5:0] opSthu = 6'd45;

	localparam logic [2:0] lsuUnitCode = 3'd2;          // dispatch code of this unit

	typedef struct packed {
		logic [5:0] opCode;
		dataWord_t operand1;                            // store data
		dataWord_t operand2;                            // base
		regAddr_t reg1;                                 // target
		regAddr_t reg2;                                 // update target
		logic [15:0] imm;                               // signed displacement
	} issue_t;

	typedef struct packed {
		logic valid;
		logic isLoad;
		logic isStore;
		accessSize_e size;
		logic algebraic;
		logic update;
		dataWord_t ea;
		block_t block;                                  // block fetched at issue
		dataWord_t storeData;
		regAddr_t reg1;
		regAddr_t reg2;
	} accessReq_t;

	typedef struct packed {
		logic enable;
		regAddr_t addr;
		dataWord_t value;
	} writeback_t;

	typedef struct packed {
		logic valid;
		logic [maxIndexBits-1:0] index;
		block_t block;
	} commit_t;

	// byte offset of the access, rounded down to the access size
	function automatic logic [offsetBits-1:0] alignedOffset(input dataWord_t ea,
		input accessSize_e size);
		logic [offsetBits-1:0] offset;
		offset = ea[offsetBits-1:0];
		if (size == sizeHalf)
			offset[0] = 1'b0;
		else if (size == sizeWord)
			offset[1:0] = 2'b00;
		return offset;
	endfunction

endpackage

`default_nettype wire

//--- src/lsuDecode.sv
`default_nettype none

module lsuDecode import lsuPkg::*; #(
	parameter int numBlocks = 128,
	localparam int indexBits = $clog2(numBlocks)
)(
	input wire clock_i,
	input wire reset_i,
	input wire enable_i,
	input wire [2:0] unitCode_i,
	input wire issue_t issue_i,
	input wire block_t readBlock_i,                     // block at blockIndex_o, same cycle
	output logic [indexBits-1:0] blockIndex_o,
	output accessReq_t request_o,
	output logic stall_o
);

	dataWord_t ea;
	logic isLoad;
	logic isStore;
	accessSize_e size;
	logic algebraic;
	logic known;                                        // opcode is one of the fourteen
	logic accept;
	logic [1:0] storeShift;                             // stores accepted one and two edges ago

	////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////
	always_comb
	begin
		isLoad = 1'b0;
		isStore = 1'b0;
		size = sizeByte;
		algebraic = 1'b0;
		known = 1'b1;
		case (issue_i.opCode)
			opLbz, opLbzu: isLoad = 1'b1;
			opLhz, opLhzu:
			begin
				isLoad = 1'b1;
				size = sizeHalf;
			end
			opLha, opLhau:
			begin
				isLoad = 1'b1;
				size = sizeHalf;
				algebraic = 1'b1;                       // sign extend on writeback
			end
			opLwz, opLwzu:
			begin
				isLoad = 1'b1;
				size = sizeWord;
			end
			opStb, opStbu: isStore = 1'b1;
			opSth, opSthu:
			begin
				isStore = 1'b1;
				size = sizeHalf;
			end
			opStw, opStwu:
			begin
				isStore = 1'b1;
				size = sizeWord;
			end
			default: known = 1'b0;                      // anything else is dropped silently
		endcase
	end

	assign ea = issue_i.operand2 + {{48{issue_i.imm[15]}}, issue_i.imm};
	assign blockIndex_o = ea[offsetBits +: indexBits]; // EA / 16, wraps at numBlocks
	assign stall_o = |storeShift;                      // hold issue until the store lands
	assign accept = enable_i && (unitCode_i == lsuUnitCode) && !stall_o && known;

	always_ff @(posedge clock_i)
	begin
		if (accept)
		begin
			request_o.isLoad <= isLoad;
			request_o.isStore <= isStore;
			request_o.size <= size;
			request_o.algebraic <= algebraic;
			request_o.update <= issue_i.opCode[0];      // update forms are the odd opcodes
			request_o.ea <= ea;
			request_o.block <= readBlock_i;
			request_o.storeData <= issue_i.operand1;
			request_o.reg1 <= issue_i.reg1;
			request_o.reg2 <= issue_i.reg2;
		end
		if (reset_i)
		begin
			request_o.valid <= 1'b0;
			storeShift <= 2'b00;
		end
		else
		begin
			request_o.valid <= accept;
			storeShift <= {storeShift[0], accept && isStore};
		end
	end

endmodule

`default_nettype wire

//--- src/dataBlockMemory.sv
`default_nettype none

module dataBlockMemory import lsuPkg::*; #(
	parameter int numBlocks = 128,
	localparam int indexBits = $clog2(numBlocks)
)(
	input wire clock_i,
	input wire reset_i,
	input wire [indexBits-1:0] readIndex_i,
	output block_t readBlock_o,
	input wire commit_t commit_i
);

	block_t memory [numBlocks];

	assign readBlock_o = memory[readIndex_i];           // combinational read

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < numBlocks; i++)
			begin
				memory[i] <= '0;                        // whole memory comes up zero
			end
		end
		else if (commit_i.valid)
		begin
			memory[commit_i.index[indexBits-1:0]] <= commit_i.block;
		end
	end

endmodule

`default_nettype wire

//--- src/storeMerge.sv
`default_nettype none

module storeMerge import lsuPkg::*; #(
	parameter int numBlocks = 128,
	localparam int indexBits = $clog2(numBlocks)
)(
	input wire clock_i,
	input wire reset_i,
	input wire accessReq_t request_i,
	output commit_t commit_o
);

	logic [offsetBits-1:0] offset;                      // aligned byte offset
	logic [indexBits-1:0] blockIndex;
	block_t merged;

	assign offset = alignedOffset(request_i.ea, request_i.size);
	assign blockIndex = request_i.ea[offsetBits +: indexBits];

	////////////////////////////////////////////////////////////
	// merge low-order store bytes into the fetched block
	////////////////////////////////////////////////////////////
	always_comb
	begin
		merged = request_i.block;
		case (request_i.size)
			sizeByte: merged[offset*8 +: 8] = request_i.storeData[7:0];
			sizeHalf: merged[offset*8 +: 16] = request_i.storeData[15:0];
			default: merged[offset*8 +: 32] = request_i.storeData[31:0];
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		commit_o.index <= maxIndexBits'(blockIndex);
		commit_o.block <= merged;
		if (reset_i)
			commit_o.valid <= 1'b0;
		else
			commit_o.valid <= request_i.valid && request_i.isStore; // write next edge
	end

endmodule

`default_nettype wire

//--- src/writebackStage.sv
`default_nettype none

module writebackStage import lsuPkg::*; (
	input wire clock_i,
	input wire reset_i,
	input wire accessReq_t request_i,
	output writeback_t wbPort1_o,                       // loaded value to reg1
	output writeback_t wbPort2_o                        // EA to reg2 for update forms
);

	logic [offsetBits-1:0] offset;
	logic [7:0] byteField;
	logic [15:0] halfField;
	logic [31:0] wordField;
	dataWord_t loadValue;

	assign offset = alignedOffset(request_i.ea, request_i.size);

	////////////////////////////////////////////////////////////
	// field extraction, leftmost block bit lands in field msb
	////////////////////////////////////////////////////////////
	always_comb
	begin
		byteField = '0;
		halfField = '0;
		wordField = '0;
		case (request_i.size)
			sizeByte: byteField = request_i.block[offset*8 +: 8];
			sizeHalf: halfField = request_i.block[offset*8 +: 16];
			default: wordField = request_i.block[offset*8 +: 32];
		endcase
	end

	// right justify, then sign or zero extend
	always_comb
	begin
		case (request_i.size)
			sizeByte: loadValue = {56'd0, byteField};
			sizeHalf:
			begin
				if (request_i.algebraic)
					loadValue = {{48{halfField[15]}}, halfField}; // lha, lhau
				else
					loadValue = {48'd0, halfField};
			end
			default: loadValue = {32'd0, wordField};
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		wbPort1_o.addr <= request_i.reg1;
		wbPort1_o.value <= loadValue;
		wbPort2_o.addr <= request_i.reg2;
		wbPort2_o.value <= request_i.ea;                // unmodified EA
		if (reset_i)
		begin
			wbPort1_o.enable <= 1'b0;
			wbPort2_o.enable <= 1'b0;
		end
		else
		begin
			wbPort1_o.enable <= request_i.valid && request_i.isLoad;
			wbPort2_o.enable <= request_i.valid && request_i.update; // loads and stores
		end
	end

endmodule

`default_nettype wire

//--- src/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit import lsuPkg::*; #(
	parameter int numBlocks = 128,                      // 128 blocks of 16 bytes, 2 KiB
	localparam int indexBits = $clog2(numBlocks)
)(
	input wire clock_i,
	input wire reset_i,
	input wire enable_i,
	input wire [2:0] unitCode_i,
	input wire issue_t issue_i,
	output logic stall_o,
	output writeback_t wbPort1_o,
	output writeback_t wbPort2_o
);

	logic [indexBits-1:0] blockIndex;                   // stage one read address
	block_t readBlock;
	accessReq_t request;                                // stage one register
	commit_t commit;                                    // stage two store commit

	////////////////////////////////////////////////////////////
	// stage one, decode and block fetch
	////////////////////////////////////////////////////////////
	lsuDecode #(
		.numBlocks(numBlocks)
	) lsuDecode_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(enable_i),
		.unitCode_i(unitCode_i),
		.issue_i(issue_i),
		.readBlock_i(readBlock),
		.blockIndex_o(blockIndex),
		.request_o(request),
		.stall_o(stall_o)
	);

	dataBlockMemory #(
		.numBlocks(numBlocks)
	) dataBlockMemory_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.readIndex_i(blockIndex),
		.readBlock_o(readBlock),
		.commit_i(commit)
	);

	////////////////////////////////////////////////////////////
	// stage two, store merge and load writeback
	////////////////////////////////////////////////////////////
	storeMerge #(
		.numBlocks(numBlocks)
	) storeMerge_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.request_i(request),
		.commit_o(commit)
	);

	writebackStage writebackStage_i (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.request_i(request),
		.wbPort1_o(wbPort1_o),
		.wbPort2_o(wbPort2_o)
	);

endmodule

`default_nettype wire

//--- bench/lsuModel.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

localparam int modelBytes = 2048;                       // 128 blocks of 16 bytes
logic [7:0] modelMem [modelBytes];                      // byte image, address is EA mod 2048

function automatic void clearModel();
	for (int i = 0; i < modelBytes; i++)
		modelMem[i] = 8'h00;
endfunction

// access width in bytes
function automatic int accessBytes(input logic [5:0] op);
	case (op)
		opLbz, opLbzu, opStb, opStbu: return 1;
		opLhz, opLhzu, opLha, opLhau, opSth, opSthu: return 2;
		default: return 4;
	endcase
endfunction

function automatic logic isUpdateOp(input logic [5:0] op);
	case (op)
		opLbzu, opLhzu, opLhau, opLwzu, opStbu, opSthu, opStwu: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic dataWord_t effAddr(input issue_t instr);
	return instr.operand2 + {{48{instr.imm[15]}}, instr.imm}; // base plus signed displacement
endfunction

// first byte of the access, rounded down to its width
function automatic int byteAddr(input dataWord_t ea, input int width);
	return int'(ea[10:0]) & ~(width - 1);
endfunction

function automatic dataWord_t predictLoad(input logic [5:0] op, input dataWord_t ea);
	int width;
	int addr;
	dataWord_t value;
	width = accessBytes(op);
	addr = byteAddr(ea, width);
	value = '0;
	for (int i = 0; i < width; i++)
		value = (value << 8) | modelMem[addr + i];      // byte 0 is most significant
	if ((op == opLha || op == opLhau) && value[15])
		value[63:16] = '1;                              // algebraic halfword
	return value;
endfunction

function automatic void applyStore(input logic [5:0] op, input dataWord_t ea,
	input dataWord_t data);
	int width;
	int addr;
	width = accessBytes(op);
	addr = byteAddr(ea, width);
	for (int i = 0; i < width; i++)
		modelMem[addr + i] = data[8*(width-1-i) +: 8]; // low-order bytes, msb first
endfunction

`endif

//--- bench/lsuBench.sv
`default_nettype none

module lsuBench import lsuPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeoutCycles = 20;
	localparam int numStores = 42;                      // multiple of the six store kinds
	localparam int burstLength = 6;
	localparam logic [10:0] windowBase = 11'h380;        // blocks 56 to 63
	localparam logic [5:0] loadOps [8] = '{opLbz, opLbzu, opLhz, opLhzu, opLha, opLhau,
		opLwz, opLwzu};
	localparam logic [5:0] storeOps [6] = '{opStb, opStbu, opSth, opSthu, opStw, opStwu};

	logic clock;
	logic reset;
	logic enable;
	logic [2:0] unitCode;
	issue_t issue;
	logic stall;
	writeback_t wbPort1;
	writeback_t wbPort2;
	integer seed = 32'h55b28eaf;

	`include "lsuModel.svh"

	loadStoreUnit #(
		.numBlocks(128)
	) loadStoreUnit_i (
		.clock_i(clock),
		.reset_i(reset),
		.enable_i(enable),
		.unitCode_i(unitCode),
		.issue_i(issue),
		.stall_o(stall),
		.wbPort1_o(wbPort1),
		.wbPort2_o(wbPort2)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;                    // 20 ns period
	end

	////////////////////////////////////////////////////////////
	// checks and waits
	////////////////////////////////////////////////////////////
	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input dataWord_t expected,
		input dataWord_t actual);
		if (actual !== expected)
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic waitStallLow();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);                           // stall is stable mid cycle
			cycles++;
			if (cycles > timeoutCycles)
			begin
				$display("Timeout waiting for stall_o to fall");
				abortRun();
			end
		end while (stall !== 1'b0);
	endtask

	task automatic waitWriteback(output int latency);
		latency = 0;
		do
		begin
			@(negedge clock);
			latency++;
			if (latency > timeoutCycles)
			begin
				$display("Timeout waiting for a load writeback on port 1");
				abortRun();
			end
		end while (wbPort1.enable !== 1'b1);
	endtask

	// port 2 carries EA and reg2 only for update forms
	task automatic checkUpdatePort(input issue_t instr, input dataWord_t ea);
		checkValue("port 2 enable", isUpdateOp(instr.opCode), wbPort2.enable);
		if (isUpdateOp(instr.opCode))
		begin
			checkValue("port 2 reg2", instr.reg2, wbPort2.addr);
			checkValue("port 2 EA", ea, wbPort2.value);
		end
	endtask

	task automatic checkQuiet(input string name);
		for (int c = 0; c < 3; c++)
		begin
			@(negedge clock);
			checkValue({name, " stall"}, 0, stall);
			checkValue({name, " port 1 enable"}, 0, wbPort1.enable);
			checkValue({name, " port 2 enable"}, 0, wbPort2.enable);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	function automatic logic [10:0] randomEaLow();
		return windowBase + (11'($random(seed)) & 11'h07f); // 8 blocks, forces reuse
	endfunction

	function automatic logic [5:0] randomLoadOp();
		return loadOps[$random(seed) & 7];
	endfunction

	// random base and displacement that land on eaLow
	function automatic issue_t randomInstr(input logic [5:0] op, input logic [10:0] eaLow);
		issue_t instr;
		dataWord_t ea;
		ea = {$random(seed), $random(seed)};
		ea[10:0] = eaLow;                               // upper bits random, index wraps
		instr.opCode = op;
		instr.operand1 = {$random(seed), $random(seed)};
		instr.imm = 16'($random(seed));
		instr.operand2 = ea - {{48{instr.imm[15]}}, instr.imm};
		instr.reg1 = 5'($random(seed));
		instr.reg2 = 5'($random(seed));
		return instr;
	endfunction

	// returns at the acceptance edge with enable dropped
	task automatic presentInstr(input issue_t instr, input logic [2:0] unit, input logic en);
		@(posedge clock);
		enable <= en;
		unitCode <= unit;
		issue <= instr;
		waitStallLow();                                 // held while a store drains
		@(posedge clock);
		enable <= 1'b0;
	endtask

	task automatic runLoad(input issue_t instr);
		dataWord_t ea;
		dataWord_t expected;
		int latency;
		ea = effAddr(instr);
		expected = predictLoad(instr.opCode, ea);
		presentInstr(instr, lsuUnitCode, 1'b1);
		waitWriteback(latency);
		checkValue("load latency", 2, latency);        // two edges after acceptance
		checkValue("load reg1", instr.reg1, wbPort1.addr);
		checkValue("load value", expected, wbPort1.value);
		checkUpdatePort(instr, ea);
	endtask

	task automatic checkStoreTiming(input issue_t instr);
		for (int c = 1; c <= 3; c++)
		begin
			@(negedge clock);
			checkValue("store stall", (c < 3), stall); // low after edge N+2
			checkValue("store port 1 enable", 0, wbPort1.enable);
			if (c == 2)
				checkUpdatePort(instr, effAddr(instr));
			else
				checkValue("store port 2 enable", 0, wbPort2.enable);
		end
	endtask

	// load presented while the store still stalls
	task automatic storeThenLoad(input issue_t store, input issue_t load);
		presentInstr(store, lsuUnitCode, 1'b1);
		applyStore(store.opCode, effAddr(store), store.operand1);
		fork
			checkStoreTiming(store);
			runLoad(load);
		join
	endtask

	task automatic backToBackLoads();
		issue_t loads [burstLength];
		dataWord_t expected [burstLength];
		for (int k = 0; k < burstLength; k++)
		begin
			loads[k] = randomInstr(randomLoadOp(), randomEaLow());
			expected[k] = predictLoad(loads[k].opCode, effAddr(loads[k]));
		end
		waitStallLow();
		for (int c = 0; c < burstLength + 2; c++)
		begin
			@(posedge clock);
			enable <= (c < burstLength);
			unitCode <= lsuUnitCode;
			if (c < burstLength)
				issue <= loads[c];                      // one load per cycle
			@(negedge clock);
			if (c < 2)
				checkValue("burst idle", 0, wbPort1.enable);
			else
			begin
				checkValue("burst enable", 1, wbPort1.enable);
				checkValue("burst reg1", loads[c-2].reg1, wbPort1.addr);
				checkValue("burst value", expected[c-2], wbPort1.value);
				checkUpdatePort(loads[c-2], effAddr(loads[c-2]));
			end
		end
	endtask

	task automatic ignoredIssues();
		logic [10:0] eaLow;
		issue_t instr;
		eaLow = randomEaLow();
		instr = randomInstr(opStw, eaLow);
		presentInstr(instr, 3'd5, 1'b1);                // other unit
		checkQuiet("wrong unit code");
		presentInstr(instr, lsuUnitCode, 1'b0);
		checkQuiet("enable low");
		instr.opCode = 6'd46;                           // lmw, not kept
		presentInstr(instr, lsuUnitCode, 1'b1);
		checkQuiet("unknown opcode");
		runLoad(randomInstr(opLwz, eaLow));             // memory untouched
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		logic [10:0] eaLow;
		reset = 1'b1;
		enable = 1'b0;
		unitCode = 3'd0;
		issue = '0;
		clearModel();
		repeat (10) @(posedge clock);                   // reset for 10 cycles
		reset <= 1'b0;
		@(negedge clock);
		checkValue("reset stall", 0, stall);
		checkValue("reset port 1 enable", 0, wbPort1.enable);
		checkValue("reset port 2 enable", 0, wbPort2.enable);
		for (int k = 0; k < 4; k++)
			runLoad(randomInstr(randomLoadOp(), 11'($random(seed)))); // cleared memory
		for (int k = 0; k < numStores; k++)
		begin
			eaLow = randomEaLow();
			storeThenLoad(randomInstr(storeOps[k % 6], eaLow),
				randomInstr(randomLoadOp(), eaLow));
			for (int j = 0; j < 8; j++)
				runLoad(randomInstr(loadOps[j], eaLow)); // every size and extension
		end
		for (int k = 0; k < 4; k++)
			backToBackLoads();
		ignoredIssues();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/lsuPkg.sv
src/lsuDecode.sv
src/dataBlockMemory.sv
src/storeMerge.sv
src/writebackStage.sv
src/loadStoreUnit.sv
+incdir+bench
bench/lsuBench.sv

//--- Bender.yml
package:
  name: loadStoreUnit

sources:
  - target: rtl
    files:
      - src/lsuPkg.sv
      - src/lsuDecode.sv
      - src/dataBlockMemory.sv
      - src/storeMerge.sv
      - src/writebackStage.sv
      - src/loadStoreUnit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lsuBench.sv
